//--- hdl/cmd_cpu_pkg.sv
//--------------------------------------------------
// Command processor shared definitions
// Bus widths, command word encoding, AHB transfer
// codes and the execute FSM states
//--------------------------------------------------
package cmd_cpu_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// Command word fields
	localparam int OP_W   = 4;
	localparam int OP_LSB = 28;
	localparam int IMM_W  = 16;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [IMM_W-1:0]  imm_t;

	// Opcodes in bits 31:28
	// Zero is HALT so that blank memory stops the engine
	typedef enum logic [OP_W-1:0] {
		OP_HALT  = 4'h0,
		OP_LOAD  = 4'h1,
		OP_STORE = 4'h2,
		OP_ADDI  = 4'h3,
		OP_JUMP  = 4'h4
	} cmd_op_t;

	// AHB-Lite htrans codes
	localparam logic [1:0] HTRANS_IDLE = 2'b00;
	localparam logic [1:0] HTRANS_NSEQ = 2'b10;

	// Execute unit states
	typedef enum logic [1:0] {
		RUN_WAIT_CMD,
		DATA_APH,
		DATA_DPH,
		HALTED
	} exec_state_t;

endpackage

//--- hdl/core_bus_if.sv
//--------------------------------------------------
// Engine side bus port
// Address phase request plus data phase strobes
//--------------------------------------------------
`timescale 1ns/1ps

interface core_bus_if
	import cmd_cpu_pkg::*;
();

	// Address phase, held by the core until aph_ready
	logic  aph_req;
	addr_t haddr;
	logic  hwrite;
	data_t wdata;

	// Responses from the port adapter
	logic  aph_ready;
	logic  dph_ready;
	logic  dph_err;
	data_t rdata;

	// Engine side
	modport core (
		output aph_req, haddr, hwrite, wdata,
		input  aph_ready, dph_ready, dph_err, rdata
	);

	// AHB adapter side
	modport port (
		input  aph_req, haddr, hwrite, wdata,
		output aph_ready, dph_ready, dph_err, rdata
	);

endinterface

//--- hdl/ahbl_master_port.sv
//--------------------------------------------------
// AHB-Lite master port adapter
// Maps engine requests onto single word transfers
// and tracks the data phase
//--------------------------------------------------
`timescale 1ns/1ps

module ahbl_master_port
	import cmd_cpu_pkg::*;
#(
	parameter bit READ_ONLY = 1'b0
) (
	input  logic       clk,
	input  logic       rst_n,
	core_bus_if.port   bus,
	output addr_t      haddr_o,
	output logic       hwrite_o,
	output logic [1:0] htrans_o,
	output logic [2:0] hsize_o,
	output logic [2:0] hburst_o,
	output logic [3:0] hprot_o,
	output logic       hmastlock_o,
	output data_t      hwdata_o,
	input  logic       hready_i,
	input  logic       hresp_i,
	input  data_t      hrdata_i
);

	// Fixed transfer attributes
	// Protection is a data access in user mode
	localparam logic [2:0] HSIZE_WORD    = 3'b010;
	localparam logic [2:0] HBURST_SINGLE = 3'b000;
	localparam logic [3:0] HPROT_DEFAULT = 4'b0001;

	logic dph_active_q;

	// --------------------------------------------------
	// Address phase

	assign haddr_o     = bus.haddr;
	assign htrans_o    = bus.aph_req ? HTRANS_NSEQ : HTRANS_IDLE;
	assign hsize_o     = HSIZE_WORD;
	assign hburst_o    = HBURST_SINGLE;
	assign hprot_o     = HPROT_DEFAULT;
	assign hmastlock_o = 1'b0;

	// Request accepted whenever the bus is ready
	assign bus.aph_ready = hready_i && bus.aph_req;

	// --------------------------------------------------
	// Data phase

	// Follows the address phase on every ready cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph_active_q <= 1'b0;
		end else if (hready_i) begin
			dph_active_q <= bus.aph_req;
		end
	end

	assign bus.dph_ready = hready_i && dph_active_q;
	assign bus.dph_err   = hready_i && dph_active_q && hresp_i;
	assign bus.rdata     = hrdata_i;

	// Write path, absent on a fetch-only port
	generate
		if (READ_ONLY) begin : g_read_only
			assign hwrite_o = 1'b0;
			assign hwdata_o = '0;
		end else begin : g_read_write
			data_t wdata_q;

			// Capture at acceptance, hold through the data phase
			always_ff @(posedge clk) begin
				if (bus.aph_ready && bus.hwrite) begin
					wdata_q <= bus.wdata;
				end
			end

			assign hwrite_o = bus.hwrite;
			assign hwdata_o = wdata_q;
		end
	endgenerate

endmodule

//--- hdl/cmd_fetch.sv
//--------------------------------------------------
// Command fetch unit
// Holds the fetch address, reads one command word
// at a time and buffers it for the execute unit
//--------------------------------------------------
`timescale 1ns/1ps

module cmd_fetch
	import cmd_cpu_pkg::*;
#(
	parameter addr_t RESET_PC = '0
) (
	input  logic     clk,
	input  logic     rst_n,
	core_bus_if.core ibus,
	input  logic     run_i,
	input  logic     cmd_take_i,
	input  logic     redirect_i,
	input  addr_t    redirect_addr_i,
	output logic     cmd_valid_o,
	output data_t    cmd_word_o,
	output logic     fetch_err_o
);

	addr_t fetch_addr_q;
	logic  buf_valid_q;
	data_t buf_word_q;
	logic  dph_busy_q;
	logic  req_hold_q;
	logic  out_of_reset_q;
	logic  fetch_req;

	// --------------------------------------------------
	// Request control

	// New fetch only with an empty buffer and nothing in flight
	// Once issued the request stays up until accepted
	assign fetch_req = req_hold_q ||
		(out_of_reset_q && run_i && !buf_valid_q && !dph_busy_q);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_of_reset_q <= 1'b0;
			req_hold_q     <= 1'b0;
			dph_busy_q     <= 1'b0;
		end else begin
			// First fetch goes out the cycle after reset
			out_of_reset_q <= 1'b1;
			// Stalled request keeps htrans stable
			req_hold_q <= fetch_req && !ibus.aph_ready;
			if (ibus.aph_ready) begin
				dph_busy_q <= 1'b1;
			end else if (ibus.dph_ready) begin
				dph_busy_q <= 1'b0;
			end
		end
	end

	// Fetch address moves on only when the command is consumed
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_addr_q <= RESET_PC;
		end else if (cmd_take_i) begin
			fetch_addr_q <= redirect_i ? redirect_addr_i : fetch_addr_q + addr_t'(4);
		end
	end

	// --------------------------------------------------
	// Command buffer

	// Bus error leaves the buffer empty
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			buf_valid_q <= 1'b0;
		end else if (ibus.dph_ready && !ibus.dph_err) begin
			buf_valid_q <= 1'b1;
		end else if (cmd_take_i) begin
			buf_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ibus.dph_ready) begin
			buf_word_q <= ibus.rdata;
		end
	end

	assign cmd_valid_o = buf_valid_q;
	assign cmd_word_o  = buf_word_q;
	assign fetch_err_o = ibus.dph_err;

	// Read-only bus
	assign ibus.aph_req = fetch_req;
	assign ibus.haddr   = fetch_addr_q;
	assign ibus.hwrite  = 1'b0;
	assign ibus.wdata   = '0;

endmodule

//--- hdl/cmd_exec.sv
//--------------------------------------------------
// Command execute unit
// Decodes commands, owns the accumulator, runs
// loads and stores and the run/halt control
//--------------------------------------------------
`timescale 1ns/1ps

module cmd_exec
	import cmd_cpu_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	core_bus_if.core dbus,
	input  logic     cmd_valid_i,
	input  data_t    cmd_word_i,
	input  logic     fetch_err_i,
	output logic     cmd_take_o,
	output logic     redirect_o,
	output addr_t    redirect_addr_o,
	output logic     run_o,
	input  logic     halt_req_i,
	input  logic     resume_i,
	output logic     halted_o,
	output logic     running_o,
	output logic     err_o
);

	exec_state_t state_q;
	exec_state_t state_d;
	data_t       acc_q;
	data_t       acc_d;
	logic        halt_pend_q;
	logic        err_q;
	cmd_op_t     cmd_op;
	imm_t        cmd_imm;
	logic        cmd_is_store;

	// --------------------------------------------------
	// Decode

	// Unknown opcodes fall into the HALT branch below
	assign cmd_op       = cmd_op_t'(cmd_word_i[OP_LSB +: OP_W]);
	assign cmd_imm      = cmd_word_i[IMM_W-1:0];
	assign cmd_is_store = (cmd_op == OP_STORE);

	// --------------------------------------------------
	// Next state

	always_comb begin
		state_d    = state_q;
		acc_d      = acc_q;
		cmd_take_o = 1'b0;
		redirect_o = 1'b0;
		case (state_q)
			RUN_WAIT_CMD: begin
				// Error first, then halt request, then the command
				if (fetch_err_i || halt_req_i || halt_pend_q) begin
					state_d = HALTED;
				end else if (cmd_valid_i) begin
					case (cmd_op)
						OP_ADDI: begin
							acc_d      = acc_q + data_t'(cmd_imm);
							cmd_take_o = 1'b1;
						end
						OP_JUMP: begin
							cmd_take_o = 1'b1;
							redirect_o = 1'b1;
						end
						OP_LOAD, OP_STORE: begin
							state_d = DATA_APH;
						end
						default: begin
							// Consumed so resume carries on after it
							cmd_take_o = 1'b1;
							state_d    = HALTED;
						end
					endcase
				end
			end
			DATA_APH: begin
				if (dbus.aph_ready) begin
					state_d = DATA_DPH;
				end
			end
			DATA_DPH: begin
				// Command retires at the end of its data phase
				if (dbus.dph_ready) begin
					cmd_take_o = 1'b1;
					if (dbus.dph_err) begin
						state_d = HALTED;
					end else begin
						if (!cmd_is_store) begin
							acc_d = dbus.rdata;
						end
						state_d = RUN_WAIT_CMD;
					end
				end
			end
			HALTED: begin
				if (resume_i && !fetch_err_i) begin
					state_d = RUN_WAIT_CMD;
				end
			end
			default: begin
				state_d = HALTED;
			end
		endcase
	end

	// --------------------------------------------------
	// Registers

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= RUN_WAIT_CMD;
			acc_q   <= '0;
		end else begin
			state_q <= state_d;
			acc_q   <= acc_d;
		end
	end

	// Halt request seen mid transfer waits for the command to retire
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			halt_pend_q <= 1'b0;
		end else if (state_d == HALTED) begin
			halt_pend_q <= 1'b0;
		end else if (halt_req_i) begin
			halt_pend_q <= 1'b1;
		end
	end

	// Sticky bus error flag
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			err_q <= 1'b0;
		end else if (fetch_err_i || dbus.dph_err) begin
			err_q <= 1'b1;
		end else if (state_q == HALTED && resume_i) begin
			err_q <= 1'b0;
		end
	end

	// --------------------------------------------------
	// Outputs

	// Command word stays in the fetch buffer until taken
	assign dbus.aph_req = (state_q == DATA_APH);
	assign dbus.haddr   = addr_t'(cmd_imm);
	assign dbus.hwrite  = cmd_is_store;
	assign dbus.wdata   = acc_q;

	assign redirect_addr_o = addr_t'(cmd_imm);
	assign run_o           = (state_q != HALTED);
	assign halted_o        = (state_q == HALTED);
	assign running_o       = !halted_o;
	assign err_o           = err_q;

endmodule

//--- hdl/cmd_cpu_2port.sv
//--------------------------------------------------
// Two port command processor
// Fetch and execute units on separate AHB-Lite
// instruction and load/store masters
//--------------------------------------------------
`timescale 1ns/1ps

module cmd_cpu_2port
	import cmd_cpu_pkg::*;
#(
	parameter addr_t RESET_PC = '0
) (
	input  logic       clk,
	input  logic       rst_n,

	// Instruction port
	output addr_t      i_haddr_o,
	output logic       i_hwrite_o,
	output logic [1:0] i_htrans_o,
	output logic [2:0] i_hsize_o,
	output logic [2:0] i_hburst_o,
	output logic [3:0] i_hprot_o,
	output logic       i_hmastlock_o,
	output data_t      i_hwdata_o,
	input  logic       i_hready_i,
	input  logic       i_hresp_i,
	input  data_t      i_hrdata_i,

	// Load/store port
	output addr_t      d_haddr_o,
	output logic       d_hwrite_o,
	output logic [1:0] d_htrans_o,
	output logic [2:0] d_hsize_o,
	output logic [2:0] d_hburst_o,
	output logic [3:0] d_hprot_o,
	output logic       d_hmastlock_o,
	output data_t      d_hwdata_o,
	input  logic       d_hready_i,
	input  logic       d_hresp_i,
	input  data_t      d_hrdata_i,

	// Run/halt control
	input  logic       halt_req_i,
	input  logic       resume_i,
	output logic       halted_o,
	output logic       running_o,
	output logic       err_o
);

	// Engine side buses
	core_bus_if ibus ();
	core_bus_if dbus ();

	// Fetch to execute strobes
	logic  cmd_valid;
	data_t cmd_word;
	logic  cmd_take;
	logic  redirect;
	addr_t redirect_addr;
	logic  fetch_err;
	logic  run;

	// --------------------------------------------------
	// Engine

	cmd_fetch #(
		.RESET_PC (RESET_PC)
	) u_cmd_fetch (
		.clk             (clk),
		.rst_n           (rst_n),
		.ibus            (ibus),
		.run_i           (run),
		.cmd_take_i      (cmd_take),
		.redirect_i      (redirect),
		.redirect_addr_i (redirect_addr),
		.cmd_valid_o     (cmd_valid),
		.cmd_word_o      (cmd_word),
		.fetch_err_o     (fetch_err)
	);

	cmd_exec u_cmd_exec (
		.clk             (clk),
		.rst_n           (rst_n),
		.dbus            (dbus),
		.cmd_valid_i     (cmd_valid),
		.cmd_word_i      (cmd_word),
		.fetch_err_i     (fetch_err),
		.cmd_take_o      (cmd_take),
		.redirect_o      (redirect),
		.redirect_addr_o (redirect_addr),
		.run_o           (run),
		.halt_req_i      (halt_req_i),
		.resume_i        (resume_i),
		.halted_o        (halted_o),
		.running_o       (running_o),
		.err_o           (err_o)
	);

	// --------------------------------------------------
	// AHB-Lite masters

	// Fetch only, no write path
	ahbl_master_port #(
		.READ_ONLY (1'b1)
	) u_iport (
		.clk         (clk),
		.rst_n       (rst_n),
		.bus         (ibus),
		.haddr_o     (i_haddr_o),
		.hwrite_o    (i_hwrite_o),
		.htrans_o    (i_htrans_o),
		.hsize_o     (i_hsize_o),
		.hburst_o    (i_hburst_o),
		.hprot_o     (i_hprot_o),
		.hmastlock_o (i_hmastlock_o),
		.hwdata_o    (i_hwdata_o),
		.hready_i    (i_hready_i),
		.hresp_i     (i_hresp_i),
		.hrdata_i    (i_hrdata_i)
	);

	ahbl_master_port #(
		.READ_ONLY (1'b0)
	) u_dport (
		.clk         (clk),
		.rst_n       (rst_n),
		.bus         (dbus),
		.haddr_o     (d_haddr_o),
		.hwrite_o    (d_hwrite_o),
		.htrans_o    (d_htrans_o),
		.hsize_o     (d_hsize_o),
		.hburst_o    (d_hburst_o),
		.hprot_o     (d_hprot_o),
		.hmastlock_o (d_hmastlock_o),
		.hwdata_o    (d_hwdata_o),
		.hready_i    (d_hready_i),
		.hresp_i     (d_hresp_i),
		.hrdata_i    (d_hrdata_i)
	);

endmodule

//--- verif/ahbl_mem_model.sv
//--------------------------------------------------
// AHB-Lite slave memory model
// Single word transfers, optional random wait
// states, one address answering with ERROR
//--------------------------------------------------
`timescale 1ns/1ps

module ahbl_mem_model
	import cmd_cpu_pkg::*;
#(
	parameter logic [31:0] SEED = 32'h8a97_6741
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       wait_en_i,
	input  addr_t      err_addr_i,
	input  addr_t      haddr_i,
	input  logic       hwrite_i,
	input  logic [1:0] htrans_i,
	input  data_t      hwdata_i,
	output logic       hready_o,
	output logic       hresp_o,
	output data_t      hrdata_o
);

	// 256 words, byte address bits 9:2
	data_t mem [0:255];

	int    seed;
	int    wait_len;
	int    wait_cnt_q;
	logic  dph_q;
	logic  dph_write_q;
	addr_t dph_addr_q;

	initial seed = SEED;

	// Read data valid for the whole data phase
	assign hrdata_o = dph_q ? mem[dph_addr_q[9:2]] : '0;

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph_q       <= 1'b0;
			dph_write_q <= 1'b0;
			dph_addr_q  <= '0;
			wait_cnt_q  <= 0;
			hready_o    <= 1'b1;
			hresp_o     <= 1'b0;
		end else if (hready_o) begin
			// Current data phase completes on this edge
			// No write on an ERROR response
			if (dph_q && dph_write_q && !hresp_o) begin
				mem[dph_addr_q[9:2]] = hwdata_i;
			end
			// Sample the next address phase
			dph_q       <= (htrans_i == HTRANS_NSEQ);
			dph_write_q <= hwrite_i;
			dph_addr_q  <= haddr_i;
			hready_o    <= 1'b1;
			hresp_o     <= 1'b0;
			if (htrans_i == HTRANS_NSEQ) begin
				if (haddr_i == err_addr_i) begin
					// First cycle of the two cycle ERROR
					hready_o <= 1'b0;
					hresp_o  <= 1'b1;
				end else if (wait_en_i) begin
					// Zero to three wait states
					wait_len = $random(seed) & 3;
					if (wait_len > 0) begin
						hready_o   <= 1'b0;
						wait_cnt_q <= wait_len - 1;
					end
				end
			end
		end else if (hresp_o) begin
			// Second ERROR cycle
			hready_o <= 1'b1;
		end else if (wait_cnt_q == 0) begin
			hready_o <= 1'b1;
		end else begin
			wait_cnt_q <= wait_cnt_q - 1;
		end
	end

endmodule

//--- verif/tb_cmd_cpu_2port.sv
//--------------------------------------------------
// Testbench for the two port command processor
// Loads command programs into the instruction
// memory model and checks data memory results
//--------------------------------------------------
`timescale 1ns/1ps

module tb_cmd_cpu_2port
	import cmd_cpu_pkg::*;
();

	localparam int    TIMEOUT_CYCLES = 4000;
	localparam addr_t NO_ERR_ADDR    = 32'hffff_fffc;

	// Single word, single burst, data access in user mode
	localparam logic [2:0] EXP_HSIZE  = 3'b010;
	localparam logic [2:0] EXP_HBURST = 3'b000;
	localparam logic [3:0] EXP_HPROT  = 4'b0001;

	logic       clk;
	logic       rst_n;
	logic       halt_req;
	logic       resume;
	logic       halted_o;
	logic       running_o;
	logic       err_o;
	logic       wait_en;
	addr_t      d_err_addr;
	int         seed;
	addr_t      prog_addr;

	// Instruction port
	addr_t      i_haddr;
	logic       i_hwrite;
	logic [1:0] i_htrans;
	logic [2:0] i_hsize;
	logic [2:0] i_hburst;
	logic [3:0] i_hprot;
	logic       i_hmastlock;
	data_t      i_hwdata;
	logic       i_hready;
	logic       i_hresp;
	data_t      i_hrdata;

	// Load/store port
	addr_t      d_haddr;
	logic       d_hwrite;
	logic [1:0] d_htrans;
	logic [2:0] d_hsize;
	logic [2:0] d_hburst;
	logic [3:0] d_hprot;
	logic       d_hmastlock;
	data_t      d_hwdata;
	logic       d_hready;
	logic       d_hresp;
	data_t      d_hrdata;

	// --------------------------------------------------
	// DUT and memories

	cmd_cpu_2port #(
		.RESET_PC (32'h0000_0000)
	) u_cmd_cpu_2port (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_haddr_o     (i_haddr),
		.i_hwrite_o    (i_hwrite),
		.i_htrans_o    (i_htrans),
		.i_hsize_o     (i_hsize),
		.i_hburst_o    (i_hburst),
		.i_hprot_o     (i_hprot),
		.i_hmastlock_o (i_hmastlock),
		.i_hwdata_o    (i_hwdata),
		.i_hready_i    (i_hready),
		.i_hresp_i     (i_hresp),
		.i_hrdata_i    (i_hrdata),
		.d_haddr_o     (d_haddr),
		.d_hwrite_o    (d_hwrite),
		.d_htrans_o    (d_htrans),
		.d_hsize_o     (d_hsize),
		.d_hburst_o    (d_hburst),
		.d_hprot_o     (d_hprot),
		.d_hmastlock_o (d_hmastlock),
		.d_hwdata_o    (d_hwdata),
		.d_hready_i    (d_hready),
		.d_hresp_i     (d_hresp),
		.d_hrdata_i    (d_hrdata),
		.halt_req_i    (halt_req),
		.resume_i      (resume),
		.halted_o      (halted_o),
		.running_o     (running_o),
		.err_o         (err_o)
	);

	// Instruction memory never answers with ERROR
	ahbl_mem_model u_imem (
		.clk (clk), .rst_n (rst_n), .wait_en_i (wait_en), .err_addr_i (NO_ERR_ADDR),
		.haddr_i (i_haddr), .hwrite_i (i_hwrite), .htrans_i (i_htrans),
		.hwdata_i (i_hwdata), .hready_o (i_hready), .hresp_o (i_hresp),
		.hrdata_o (i_hrdata)
	);

	ahbl_mem_model u_dmem (
		.clk (clk), .rst_n (rst_n), .wait_en_i (wait_en), .err_addr_i (d_err_addr),
		.haddr_i (d_haddr), .hwrite_i (d_hwrite), .htrans_i (d_htrans),
		.hwdata_i (d_hwdata), .hready_o (d_hready), .hresp_o (d_hresp),
		.hrdata_o (d_hrdata)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// --------------------------------------------------
	// Helpers

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic value_mismatch(input string name, input data_t exp, input data_t act);
		report_error($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
	endtask

	// Opcode in bits 31:28 and operand in bits 15:0
	function automatic data_t encode_cmd(input cmd_op_t op, input imm_t imm);
		return {op, 12'h000, imm};
	endfunction

	// Background pattern of untouched data words
	function automatic data_t data_fill(input addr_t addr);
		return addr ^ 32'hd5a0_0000;
	endfunction

	task automatic emit(input cmd_op_t op, input imm_t imm);
		u_imem.mem[prog_addr[9:2]] = encode_cmd(op, imm);
		prog_addr = prog_addr + 4;
	endtask

	// Blank instruction memory holds HALT commands
	task automatic clear_memories();
		for (int i = 0; i < 256; i++) begin
			u_imem.mem[i] = encode_cmd(OP_HALT, imm_t'(i * 4));
			u_dmem.mem[i] = data_fill(addr_t'(i * 4));
		end
		prog_addr = '0;
	endtask

	task automatic check_word(input string name, input addr_t addr, input data_t exp);
		data_t act;
		act = u_dmem.mem[addr[9:2]];
		assert (act === exp) else value_mismatch(name, exp, act);
	endtask

	task automatic verify_attrs(input string name, input logic [2:0] hsize,
			input logic [2:0] hburst, input logic [3:0] hprot, input logic hmastlock);
		assert (hsize === EXP_HSIZE) else
			value_mismatch({name, " hsize"}, EXP_HSIZE, hsize);
		assert (hburst === EXP_HBURST) else
			value_mismatch({name, " hburst"}, EXP_HBURST, hburst);
		assert (hprot === EXP_HPROT) else
			value_mismatch({name, " hprot"}, EXP_HPROT, hprot);
		assert (hmastlock === 1'b0) else
			value_mismatch({name, " hmastlock"}, 0, hmastlock);
	endtask

	// Both ports idle and the engine reports running while in reset
	task automatic apply_reset();
		@(negedge clk);
		rst_n = 1'b0;
		repeat (5) begin
			@(negedge clk);
			assert (i_htrans == HTRANS_IDLE) else
				value_mismatch("reset i_htrans", HTRANS_IDLE, i_htrans);
			assert (d_htrans == HTRANS_IDLE) else
				value_mismatch("reset d_htrans", HTRANS_IDLE, d_htrans);
			assert (halted_o == 1'b0) else value_mismatch("reset halted_o", 0, halted_o);
			assert (running_o == 1'b1) else value_mismatch("reset running_o", 1, running_o);
			assert (err_o == 1'b0) else value_mismatch("reset err_o", 0, err_o);
		end
		rst_n = 1'b1;
	endtask

	task automatic wait_halted(input string name);
		int n;
		n = 0;
		while (!halted_o && n < TIMEOUT_CYCLES) begin
			@(negedge clk);
			n++;
		end
		assert (halted_o) else report_error($sformatf("%s: timeout waiting for halted_o", name));
	endtask

	task automatic pulse_halt();
		@(negedge clk);
		halt_req = 1'b1;
		@(negedge clk);
		halt_req = 1'b0;
	endtask

	task automatic pulse_resume();
		@(negedge clk);
		resume = 1'b1;
		@(negedge clk);
		resume = 1'b0;
	endtask

	// Fetch port is read only
	// Both ports carry fixed single word attributes
	always @(negedge clk) begin
		assert (i_hwrite !== 1'b1) else report_error("Instruction port drove hwrite high");
		assert (i_hwdata === '0) else value_mismatch("i_hwdata", '0, i_hwdata);
		verify_attrs("i_port", i_hsize, i_hburst, i_hprot, i_hmastlock);
		verify_attrs("d_port", d_hsize, d_hburst, d_hprot, d_hmastlock);
	end

	// --------------------------------------------------
	// Tests

	task automatic after_reset_check();
		clear_memories();
		emit(OP_ADDI, 16'd5);
		emit(OP_STORE, 16'h0100);
		emit(OP_HALT, 16'h0000);
		apply_reset();
		wait_halted("after_reset");
		check_word("after_reset", 32'h100, 32'd5);
		assert (err_o == 1'b0) else value_mismatch("after_reset err_o", 0, err_o);
	endtask

	task automatic random_wait_run();
		data_t acc;
		data_t exp_q[$];
		imm_t  imm;
		clear_memories();
		acc = '0;
		for (int i = 0; i < 12; i++) begin
			imm = imm_t'($random(seed));
			acc = acc + data_t'(imm);
			exp_q.push_back(acc);
			emit(OP_ADDI, imm);
			emit(OP_STORE, imm_t'(16'h0200 + i * 4));
		end
		emit(OP_HALT, 16'h0000);
		wait_en = 1'b1;
		apply_reset();
		wait_halted("random_wait");
		for (int i = 0; i < 12; i++) begin
			check_word($sformatf("random_wait slot %0d", i), addr_t'(32'h200 + i * 4), exp_q[i]);
		end
		wait_en = 1'b0;
	endtask

	task automatic round_trip_jump();
		clear_memories();
		u_dmem.mem[32'h180 >> 2] = 32'h1234_5678;
		emit(OP_LOAD, 16'h0180);
		emit(OP_ADDI, 16'h0042);
		emit(OP_STORE, 16'h0184);
		emit(OP_JUMP, 16'h0014);
		// Skipped by the jump
		emit(OP_STORE, 16'h0188);
		emit(OP_HALT, 16'h0000);
		apply_reset();
		wait_halted("round_trip");
		check_word("round_trip result", 32'h184, 32'h1234_5678 + 32'h42);
		check_word("round_trip skipped store", 32'h188, data_fill(32'h188));
	endtask

	task automatic run_halt_control();
		data_t acc;
		data_t exp_q[$];
		data_t word;
		int    done_cnt;
		bit    in_prefix;
		clear_memories();
		acc = '0;
		for (int i = 0; i < 16; i++) begin
			acc = acc + data_t'(i + 1);
			exp_q.push_back(acc);
			emit(OP_ADDI, imm_t'(i + 1));
			emit(OP_STORE, imm_t'(16'h0300 + i * 4));
		end
		emit(OP_HALT, 16'h0000);
		apply_reset();
		repeat (40) @(negedge clk);
		pulse_halt();
		wait_halted("run_halt");
		assert (halted_o && !running_o) else
			report_error("run_halt: engine not halted after halt request");
		// Finished stores, then untouched words only
		done_cnt  = 0;
		in_prefix = 1'b1;
		for (int i = 0; i < 16; i++) begin
			word = u_dmem.mem[(32'h300 + i * 4) >> 2];
			if (in_prefix && word == exp_q[i]) begin
				done_cnt++;
			end else begin
				in_prefix = 1'b0;
				check_word("run_halt untouched", addr_t'(32'h300 + i * 4),
					data_fill(32'h300 + i * 4));
			end
		end
		assert (done_cnt < 16) else
			report_error("run_halt: program finished before the halt request");
		pulse_resume();
		assert (running_o) else report_error("run_halt: engine not running after resume");
		wait_halted("run_halt resume");
		for (int i = 0; i < 16; i++) begin
			check_word($sformatf("run_halt slot %0d", i), addr_t'(32'h300 + i * 4), exp_q[i]);
		end
	endtask

	task automatic error_response();
		clear_memories();
		emit(OP_ADDI, 16'd7);
		emit(OP_STORE, 16'h01c0);
		emit(OP_STORE, 16'h01c4);
		emit(OP_HALT, 16'h0000);
		d_err_addr = 32'h1c0;
		apply_reset();
		wait_halted("error");
		assert (err_o == 1'b1) else value_mismatch("error err_o", 1, err_o);
		// Engine stays put while halted
		repeat (20) @(negedge clk);
		assert (halted_o) else report_error("error: engine left the halted state on its own");
		check_word("error failed store", 32'h1c0, data_fill(32'h1c0));
		check_word("error later store", 32'h1c4, data_fill(32'h1c4));
		pulse_resume();
		assert (err_o == 1'b0) else value_mismatch("error err_o after resume", 0, err_o);
		wait_halted("error resume");
		check_word("error store after resume", 32'h1c4, 32'd7);
		assert (err_o == 1'b0) else value_mismatch("error err_o at end", 0, err_o);
		d_err_addr = NO_ERR_ADDR;
	endtask

	// --------------------------------------------------
	// Main sequence

	initial begin
		rst_n      = 1'b0;
		halt_req   = 1'b0;
		resume     = 1'b0;
		wait_en    = 1'b0;
		d_err_addr = NO_ERR_ADDR;
		seed       = 32'h8a97_6741;
		prog_addr  = '0;

		after_reset_check();
		random_wait_run();
		round_trip_jump();
		run_halt_control();
		error_response();

		$display("TEST OK");
		$finish;
	end

endmodule

//--- cmd_cpu_2port.f
hdl/cmd_cpu_pkg.sv
hdl/core_bus_if.sv
hdl/ahbl_master_port.sv
hdl/cmd_fetch.sv
hdl/cmd_exec.sv
hdl/cmd_cpu_2port.sv
verif/ahbl_mem_model.sv
verif/tb_cmd_cpu_2port.sv
